/* common/escTxPkg.sv */
package escTxPkg;

    //====================
    // Widths
    //====================

    parameter int EscByteWidth = 8;         // Bits per command or data byte
    parameter int LineWidth    = 3;         // Wires A, B, C

    //====================
    // Line states (A B C)
    //====================

    parameter logic [LineWidth-1:0] LineStop     = 3'b111;
    parameter logic [LineWidth-1:0] LineMark     = 3'b101;  // Entry and exit mark
    parameter logic [LineWidth-1:0] LineSpace    = 3'b000;  // Also the ULPS hold
    parameter logic [LineWidth-1:0] LineOne      = 3'b110;
    parameter logic [LineWidth-1:0] LineZero     = 3'b011;
    parameter logic [LineWidth-1:0] LineUlpsWake = 3'b100;

    //====================
    // Escape command codes
    //====================

    // Sent MSB first right after the entry sequence
    parameter logic [EscByteWidth-1:0] CmdLpdt     = 8'hE1;
    parameter logic [EscByteWidth-1:0] CmdUlps     = 8'h1E;

    // Triggers, one per TxTriggerEsc bit
    parameter logic [EscByteWidth-1:0] CmdTrigger0 = 8'h62;
    parameter logic [EscByteWidth-1:0] CmdTrigger1 = 8'h5D;
    parameter logic [EscByteWidth-1:0] CmdTrigger2 = 8'h21;
    parameter logic [EscByteWidth-1:0] CmdTrigger3 = 8'hA0;

endpackage

/* escTx/escLaneCtrl.sv */
module escLaneCtrl
    import escTxPkg::*;
#(
    parameter int UlpsExitCycles = 4
) (
    input  logic                    TxClkEsc,
    input  logic                    RstN_EscClk,
    input  logic                    TxReqEsc,
    input  logic                    TxLpdtEsc,
    input  logic                    TxUlpsEsc,
    input  logic                    TxUlpsExit,
    input  logic                    TxValidEsc,
    input  logic [3:0]              TxTriggerEsc,
    input  logic [EscByteWidth-1:0] TxDataEsc,
    input  logic                    byteDone,
    input  logic                    bitValid,
    output logic                    loadByte,
    output logic [EscByteWidth-1:0] loadValue,
    output logic [LineWidth-1:0]    lineReq,
    output logic                    lineOverride,
    output logic                    TxReadyEsc,
    output logic                    LpTxEn,
    output logic                    Stopstate,
    output logic                    UlpsActiveNot
);

    localparam int WakeCntWidth = $clog2(UlpsExitCycles + 1);

    localparam logic [2:0] StStop       = 3'd0;
    localparam logic [2:0] StEntryMark  = 3'd1;
    localparam logic [2:0] StEntrySpace = 3'd2;
    localparam logic [2:0] StCommand    = 3'd3;
    localparam logic [2:0] StLpdtData   = 3'd4;
    localparam logic [2:0] StUlpsHold   = 3'd5;
    localparam logic [2:0] StUlpsWake   = 3'd6;
    localparam logic [2:0] StExitMark   = 3'd7;

    logic [2:0]              state;
    logic [2:0]              nextState;
    logic [EscByteWidth-1:0] cmdSel;
    logic [EscByteWidth-1:0] cmdCode;     // Command of the current escape
    logic [WakeCntWidth-1:0] wakeCnt;
    logic                    reqValid;
    logic                    wakeLast;

    //====================
    // Request decode
    //====================

    assign reqValid = TxReqEsc & (TxLpdtEsc | TxUlpsEsc | (|TxTriggerEsc));

    // LPDT over ULPS over triggers, lowest trigger first
    always_comb begin
        if (TxLpdtEsc)            cmdSel = CmdLpdt;
        else if (TxUlpsEsc)       cmdSel = CmdUlps;
        else if (TxTriggerEsc[0]) cmdSel = CmdTrigger0;
        else if (TxTriggerEsc[1]) cmdSel = CmdTrigger1;
        else if (TxTriggerEsc[2]) cmdSel = CmdTrigger2;
        else                      cmdSel = CmdTrigger3;
    end

    always_ff @(posedge TxClkEsc) begin
        if (state == StStop && reqValid) cmdCode <= cmdSel;
    end

    //====================
    // State machine
    //====================

    assign wakeLast = (wakeCnt == WakeCntWidth'(UlpsExitCycles - 1));

    always_comb begin
        nextState = state;
        case (state)
            StStop:       if (reqValid) nextState = StEntryMark;
            StEntryMark:  nextState = StEntrySpace;
            StEntrySpace: nextState = StCommand;     // Command byte loads here
            StCommand: begin
                if (byteDone) begin
                    if (cmdCode == CmdLpdt)      nextState = StLpdtData;
                    else if (cmdCode == CmdUlps) nextState = StUlpsHold;
                    else                         nextState = StExitMark;  // Trigger
                end
            end
            StLpdtData:   if (!TxReqEsc && !bitValid) nextState = StExitMark;
            StUlpsHold:   if (TxUlpsExit) nextState = StUlpsWake;
            StUlpsWake:   if (wakeLast) nextState = StStop;
            default:      nextState = StStop;             // Exit mark
        endcase
    end

    always_ff @(posedge TxClkEsc or negedge RstN_EscClk) begin
        if (!RstN_EscClk) begin
            state   <= StStop;
            wakeCnt <= '0;
        end else begin
            state   <= nextState;
            wakeCnt <= (state == StUlpsWake) ? wakeCnt + 1'b1 : '0;
        end
    end

    // Fixed line states outside of bit transmission
    always_comb begin
        lineOverride = 1'b1;
        lineReq      = LineSpace;
        case (state)
            StStop:                  lineReq = LineStop;
            StEntryMark, StExitMark: lineReq = LineMark;
            StUlpsWake:              lineReq = LineUlpsWake;
            StCommand, StLpdtData:   lineOverride = 1'b0;
            default:                 lineReq = LineSpace;
        endcase
    end

    // Byte transfer, only when the shifter is free or frees up now
    assign TxReadyEsc = (state == StLpdtData) & TxReqEsc & (~bitValid | byteDone);
    assign loadByte   = (state == StEntrySpace) | (TxReadyEsc & TxValidEsc);
    assign loadValue  = (state == StEntrySpace) ? cmdCode : TxDataEsc;

    // Status follows the state by one cycle, in step with LpTx
    always_ff @(posedge TxClkEsc or negedge RstN_EscClk) begin
        if (!RstN_EscClk) begin
            Stopstate     <= 1'b1;
            LpTxEn        <= 1'b0;
            UlpsActiveNot <= 1'b1;
        end else begin
            Stopstate     <= (state == StStop);
            LpTxEn        <= (state != StStop);
            UlpsActiveNot <= !(state == StUlpsHold || state == StUlpsWake);
        end
    end

endmodule

/* escTx/escBitShifter.sv */
module escBitShifter
    import escTxPkg::*;
(
    input  logic                    TxClkEsc,
    input  logic                    RstN_EscClk,
    input  logic                    loadByte,
    input  logic [EscByteWidth-1:0] loadValue,
    input  logic                    bitDone,
    output logic                    curBit,
    output logic                    bitValid,
    output logic                    byteDone
);

    localparam int CntWidth = $clog2(EscByteWidth);

    logic [EscByteWidth-1:0] shiftReg;
    logic [CntWidth-1:0]     bitCnt;      // Index of the bit on curBit
    logic                    lastBit;

    assign curBit   = shiftReg[EscByteWidth-1];   // MSB first
    assign lastBit  = (bitCnt == CntWidth'(EscByteWidth - 1));
    assign byteDone = bitDone & lastBit;

    // Byte payload
    always_ff @(posedge TxClkEsc) begin
        if (loadByte) begin
            shiftReg <= loadValue;
        end else if (bitDone) begin
            shiftReg <= {shiftReg[EscByteWidth-2:0], 1'b0};
        end
    end

    always_ff @(posedge TxClkEsc or negedge RstN_EscClk) begin
        if (!RstN_EscClk) begin
            bitValid <= 1'b0;
            bitCnt   <= '0;
        end else if (loadByte) begin
            // A new byte may follow the last bit back to back
            bitValid <= 1'b1;
            bitCnt   <= '0;
        end else if (bitDone) begin
            bitCnt <= bitCnt + 1'b1;
            if (lastBit) begin
                bitValid <= 1'b0;
            end
        end
    end

endmodule

/* escTx/escLineEncoder.sv */
module escLineEncoder
    import escTxPkg::*;
(
    input  logic                 TxClkEsc,
    input  logic                 RstN_EscClk,
    input  logic                 curBit,
    input  logic                 bitValid,
    input  logic [LineWidth-1:0] lineReq,
    input  logic                 lineOverride,
    output logic [LineWidth-1:0] LpTx,
    output logic                 bitDone
);

    logic                 spacePhase;   // Space half of the bit being selected
    logic                 bitActive;
    logic [LineWidth-1:0] lineNext;

    assign bitActive = bitValid & ~lineOverride;
    assign bitDone   = bitActive & spacePhase;

    always_comb begin
        if (lineOverride) begin
            lineNext = lineReq;
        end else if (!bitValid || spacePhase) begin
            lineNext = LineSpace;             // Also covers LPDT back-pressure
        end else begin
            lineNext = curBit ? LineOne : LineZero;
        end
    end

    always_ff @(posedge TxClkEsc or negedge RstN_EscClk) begin
        if (!RstN_EscClk) begin
            spacePhase <= 1'b0;
            LpTx       <= LineStop;
        end else begin
            spacePhase <= bitActive & ~spacePhase;
            LpTx       <= lineNext;
        end
    end

endmodule

/* rtl/lpContentionDetect.sv */
module lpContentionDetect
    import escTxPkg::*;
(
    input  logic                 TxClkEsc,
    input  logic                 RstN_EscClk,
    input  logic [LineWidth-1:0] LpTx,
    input  logic                 LpTxEn,
    input  logic [LineWidth-1:0] LpRx,
    output logic                 ErrContentionLp0,
    output logic                 ErrContentionLp1
);

    // Per wire compare of driven and sampled levels
    always_ff @(posedge TxClkEsc or negedge RstN_EscClk) begin
        if (!RstN_EscClk) begin
            ErrContentionLp0 <= 1'b0;
            ErrContentionLp1 <= 1'b0;
        end else begin
            ErrContentionLp0 <= LpTxEn & (|(LpTx & ~LpRx));  // Driven high, read low
            ErrContentionLp1 <= LpTxEn & (|(~LpTx & LpRx));  // Driven low, read high
        end
    end

endmodule

/* rtl/escTxTop.sv */
module escTxTop
    import escTxPkg::*;
#(
    parameter int UlpsExitCycles = 4
) (
    input  logic                    TxClkEsc,
    input  logic                    RstN_EscClk,
    input  logic                    TxReqEsc,
    input  logic                    TxLpdtEsc,
    input  logic                    TxUlpsEsc,
    input  logic                    TxUlpsExit,
    input  logic                    TxValidEsc,
    input  logic [3:0]              TxTriggerEsc,
    input  logic [EscByteWidth-1:0] TxDataEsc,
    input  logic [LineWidth-1:0]    LpRx,           // Sampled A B C
    output logic                    TxReadyEsc,
    output logic                    LpTxEn,
    output logic                    Stopstate,
    output logic                    UlpsActiveNot,
    output logic                    ErrContentionLp0,
    output logic                    ErrContentionLp1,
    output logic [LineWidth-1:0]    LpTx
);

    // Controller to shifter
    logic                    loadByte;
    logic [EscByteWidth-1:0] loadValue;
    logic                    byteDone;

    // Shifter to encoder
    logic                    bitValid;
    logic                    curBit;
    logic                    bitDone;

    // Controller to encoder
    logic [LineWidth-1:0]    lineReq;
    logic                    lineOverride;

    escLaneCtrl #(
        .UlpsExitCycles (UlpsExitCycles)
    ) laneCtrl (
        .TxClkEsc      (TxClkEsc),
        .RstN_EscClk   (RstN_EscClk),
        .TxReqEsc      (TxReqEsc),
        .TxLpdtEsc     (TxLpdtEsc),
        .TxUlpsEsc     (TxUlpsEsc),
        .TxUlpsExit    (TxUlpsExit),
        .TxValidEsc    (TxValidEsc),
        .TxTriggerEsc  (TxTriggerEsc),
        .TxDataEsc     (TxDataEsc),
        .byteDone      (byteDone),
        .bitValid      (bitValid),
        .loadByte      (loadByte),
        .loadValue     (loadValue),
        .lineReq       (lineReq),
        .lineOverride  (lineOverride),
        .TxReadyEsc    (TxReadyEsc),
        .LpTxEn        (LpTxEn),
        .Stopstate     (Stopstate),
        .UlpsActiveNot (UlpsActiveNot)
    );

    escBitShifter bitShifter (
        .TxClkEsc    (TxClkEsc),
        .RstN_EscClk (RstN_EscClk),
        .loadByte    (loadByte),
        .loadValue   (loadValue),
        .bitDone     (bitDone),
        .curBit      (curBit),
        .bitValid    (bitValid),
        .byteDone    (byteDone)
    );

    escLineEncoder lineEncoder (
        .TxClkEsc     (TxClkEsc),
        .RstN_EscClk  (RstN_EscClk),
        .curBit       (curBit),
        .bitValid     (bitValid),
        .lineReq      (lineReq),
        .lineOverride (lineOverride),
        .LpTx         (LpTx),
        .bitDone      (bitDone)
    );

    lpContentionDetect contentionDetect (
        .TxClkEsc         (TxClkEsc),
        .RstN_EscClk      (RstN_EscClk),
        .LpTx             (LpTx),
        .LpTxEn           (LpTxEn),
        .LpRx             (LpRx),
        .ErrContentionLp0 (ErrContentionLp0),
        .ErrContentionLp1 (ErrContentionLp1)
    );

endmodule

/* dv/escTxAssertions.sv */
module escTxAssertions
    import escTxPkg::*;
#(
    parameter int UlpsExitCycles = 4
) (
    input logic                    TxClkEsc,
    input logic                    RstN_EscClk,
    input logic                    TxReqEsc,
    input logic                    TxLpdtEsc,
    input logic                    TxUlpsEsc,
    input logic [3:0]              TxTriggerEsc,
    input logic                    TxValidEsc,
    input logic                    TxReadyEsc,
    input logic [EscByteWidth-1:0] TxDataEsc,
    input logic [LineWidth-1:0]    LpTx,
    input logic [LineWidth-1:0]    LpRx,
    input logic                    LpTxEn,
    input logic                    Stopstate,
    input logic                    UlpsActiveNot,
    input logic                    ErrContentionLp0,
    input logic                    ErrContentionLp1
);

    int                      errCount = 0;
    string                   errName = "";
    logic [LineWidth-1:0]    errExp = '0;
    logic [LineWidth-1:0]    errAct = '0;
    logic [EscByteWidth-1:0] expCmd = '0;   // Command of the escape in progress

    function automatic logic [LineWidth-1:0] symFor(input logic [EscByteWidth-1:0] b,
                                                    input int idx);
        return b[idx] ? LineOne : LineZero;
    endfunction

    task automatic recordFailure(input string name, input logic [LineWidth-1:0] exp,
                                 input logic [LineWidth-1:0] act);
        errCount++;
        errName = name;
        errExp  = exp;
        errAct  = act;
    endtask

    // Priority LPDT, ULPS, then lowest trigger
    always @(posedge TxClkEsc) begin
        if (Stopstate && TxReqEsc) begin
            if (TxLpdtEsc)            expCmd <= CmdLpdt;
            else if (TxUlpsEsc)       expCmd <= CmdUlps;
            else if (TxTriggerEsc[0]) expCmd <= CmdTrigger0;
            else if (TxTriggerEsc[1]) expCmd <= CmdTrigger1;
            else if (TxTriggerEsc[2]) expCmd <= CmdTrigger2;
            else                      expCmd <= CmdTrigger3;
        end
    end

    //====================
    // Reset, entry, exit
    //====================

    assert property (@(posedge TxClkEsc) $rose(RstN_EscClk) |-> LpTx == LineStop && Stopstate
            && !LpTxEn && !TxReadyEsc && UlpsActiveNot && !ErrContentionLp0 && !ErrContentionLp1)
        else begin
            recordFailure("reset values", LineStop, LpTx);
            $error("reset values");
        end

    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            $fell(Stopstate) |-> LpTx == LineMark && LpTxEn ##1 LpTx == LineSpace)
        else begin
            recordFailure("entry sequence", LineMark, LpTx);
            $error("entry sequence");
        end

    // Plain exit goes through the mark, ULPS exit through the wake state
    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            $rose(Stopstate) && !$rose(UlpsActiveNot) |->
            $past(LpTx) == LineMark && LpTx == LineStop && !LpTxEn)
        else begin
            recordFailure("exit sequence", LineStop, LpTx);
            $error("exit sequence");
        end

    //====================
    // Bits on the line
    //====================

    for (genvar i = 0; i < EscByteWidth; i++) begin : bitChk
        localparam int Dly = 2 + 2 * (EscByteWidth - 1 - i);

        assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
                $fell(Stopstate) |-> ##Dly LpTx == symFor(expCmd, i) ##1 LpTx == LineSpace)
            else begin
                recordFailure("command bit", symFor(expCmd, i), LpTx);
                $error("command bit %0d", i);
            end

        assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
                TxReadyEsc && TxValidEsc |-> ##Dly
                LpTx == symFor($past(TxDataEsc, Dly), i) ##1 LpTx == LineSpace)
            else begin
                recordFailure("data bit", symFor($past(TxDataEsc, Dly), i), LpTx);
                $error("data bit %0d", i);
            end
    end

    // No byte offered while the shifter is free, so the line stays in space
    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            TxReadyEsc && !TxValidEsc |=> LpTx == LineSpace)
        else begin
            recordFailure("LPDT back-pressure", LineSpace, LpTx);
            $error("LPDT back-pressure");
        end

    //====================
    // ULPS and contention
    //====================

    // Space for the whole hold, wake only on the way out
    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            !UlpsActiveNot |-> LpTx == LineSpace || LpTx == LineUlpsWake)
        else begin
            recordFailure("ULPS hold", LineSpace, LpTx);
            $error("ULPS hold");
        end

    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            $rose(LpTx == LineUlpsWake) |->
            (LpTx == LineUlpsWake)[*UlpsExitCycles] ##1 (LpTx == LineStop && UlpsActiveNot))
        else begin
            recordFailure("ULPS wake", LineUlpsWake, LpTx);
            $error("ULPS wake");
        end

    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            LpTxEn && |(LpTx & ~LpRx) |=> ErrContentionLp0)
        else begin
            recordFailure("contention LP0", LineWidth'(1), LineWidth'(ErrContentionLp0));
            $error("contention LP0");
        end

    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            LpTxEn && |(~LpTx & LpRx) |=> ErrContentionLp1)
        else begin
            recordFailure("contention LP1", LineWidth'(1), LineWidth'(ErrContentionLp1));
            $error("contention LP1");
        end

    assert property (@(posedge TxClkEsc) disable iff (!RstN_EscClk)
            LpRx == LpTx |=> !ErrContentionLp0 && !ErrContentionLp1)
        else begin
            recordFailure("no contention", '0,
                          LineWidth'({ErrContentionLp1, ErrContentionLp0}));
            $error("no contention");
        end

endmodule

bind escTxTop escTxAssertions #(.UlpsExitCycles(UlpsExitCycles)) protocolChecks (.*);

/* dv/escTxTb.sv */
module escTxTb
    import escTxPkg::*;
;

    localparam int Timeout = 2000;

    logic                    TxClkEsc = 1'b0;
    logic                    RstN_EscClk;
    logic                    TxReqEsc;
    logic                    TxLpdtEsc;
    logic                    TxUlpsEsc;
    logic                    TxUlpsExit;
    logic                    TxValidEsc;
    logic [3:0]              TxTriggerEsc;
    logic [EscByteWidth-1:0] TxDataEsc;
    logic [LineWidth-1:0]    LpRx;
    logic [LineWidth-1:0]    rxFlip;          // Wires read inverted
    logic                    TxReadyEsc;
    logic                    LpTxEn;
    logic                    Stopstate;
    logic                    UlpsActiveNot;
    logic                    ErrContentionLp0;
    logic                    ErrContentionLp1;
    logic [LineWidth-1:0]    LpTx;
    logic [31:0]             lcgState = 32'h57ae;

    escTxTop UUT (.*);

    always #20 TxClkEsc = ~TxClkEsc;

    assign LpRx = LpTx ^ rxFlip;

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stepCycles(input int n);
        repeat (n) @(posedge TxClkEsc);
        #5;
    endtask

    task automatic timeoutFail(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    // First assertion failure ends the run
    always @(negedge TxClkEsc) begin
        if (UUT.protocolChecks.errCount != 0) begin
            $display("** Error %s: expected %h, actual %h", UUT.protocolChecks.errName,
                     UUT.protocolChecks.errExp, UUT.protocolChecks.errAct);
            $display("Simulation finished: FAIL");
            $fatal(1);
        end
    end

    task automatic sendByte();
        int t;
        lcgState   = lcgNext(lcgState);
        TxDataEsc  = lcgState[23:16];
        TxValidEsc = 1'b1;
        t = 0;
        do begin
            @(negedge TxClkEsc);
            t++;
            if (t > Timeout) timeoutFail("TxReadyEsc");
        end while (!TxReadyEsc);
        stepCycles(1);
        TxValidEsc = 1'b0;
    endtask

    task automatic waitStop();
        int t;
        t = 0;
        do begin
            @(negedge TxClkEsc);
            t++;
            if (t > Timeout) timeoutFail("the stop state");
        end while (!(Stopstate && UlpsActiveNot));
        stepCycles(1);
    endtask

    initial begin
        int t;
        RstN_EscClk  = 1'b0;
        TxReqEsc     = 1'b0;
        TxLpdtEsc    = 1'b0;
        TxUlpsEsc    = 1'b0;
        TxUlpsExit   = 1'b0;
        TxValidEsc   = 1'b0;
        TxTriggerEsc = '0;
        TxDataEsc    = '0;
        rxFlip       = '0;
        stepCycles(5);
        RstN_EscClk = 1'b1;
        stepCycles(3);

        // LPDT with a back-pressure gap
        TxReqEsc  = 1'b1;
        TxLpdtEsc = 1'b1;
        sendByte();
        sendByte();
        stepCycles(25);
        sendByte();
        sendByte();
        TxReqEsc  = 1'b0;
        TxLpdtEsc = 1'b0;
        waitStop();

        // ULPS entry and wake
        TxReqEsc  = 1'b1;
        TxUlpsEsc = 1'b1;
        t = 0;
        do begin
            @(negedge TxClkEsc);
            t++;
            if (t > Timeout) timeoutFail("ULPS entry");
        end while (UlpsActiveNot);
        stepCycles(1);
        TxReqEsc  = 1'b0;
        TxUlpsEsc = 1'b0;
        stepCycles(8);
        TxUlpsExit = 1'b1;
        stepCycles(1);
        TxUlpsExit = 1'b0;
        waitStop();

        // Trigger 2, with contention during the command byte
        TxReqEsc     = 1'b1;
        TxTriggerEsc = 4'b0100;
        stepCycles(1);
        TxReqEsc     = 1'b0;
        TxTriggerEsc = '0;
        stepCycles(6);
        rxFlip = 3'b111;
        stepCycles(6);
        rxFlip = '0;
        waitStop();

        stepCycles(4);
        if (UUT.protocolChecks.errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

/* build.f */
common/escTxPkg.sv
escTx/escLaneCtrl.sv
escTx/escBitShifter.sv
escTx/escLineEncoder.sv
rtl/lpContentionDetect.sv
rtl/escTxTop.sv
dv/escTxAssertions.sv
dv/escTxTb.sv
